// ==== include/pyramid_consts.svh ====
`ifndef PYRAMID_CONSTS_SVH
`define PYRAMID_CONSTS_SVH

// Greyscale pixel width
`define PIX_BITS 8

// Octave-1 image size, octave 2 is half of it in each direction
`define IMG_WIDTH 16
`define IMG_HEIGHT 16
`define ADDR_BITS 8

// Source memory read latency in cycles
`define EXT_LATENCY 2

// Kernel weights sum to 16 for blur, 4 for the 2x2 average
`define BLUR_SHIFT 4
`define HALVE_SHIFT 2

`endif

// ==== verilog/pyramid_pkg.sv ====
`default_nettype none
`include "pyramid_consts.svh"

package pyramid_pkg;

    // Sequencer passes, one per pyramid level
    typedef enum logic [2:0] {IDLE, LOAD, BLUR1, HALVE, BLUR2} seq_state_t;

    // Shared kernel engine operation
    typedef enum logic {OP_BLUR, OP_HALVE} kernel_op_t;

    // Output level tag, in write order
    typedef enum logic [1:0] {O1L1, O1L2, O2L1, O2L2} level_t;

    // One pixel write into a frame
    typedef struct packed {
        logic                  valid;
        logic [`ADDR_BITS-1:0] addr;
        logic [`PIX_BITS-1:0]  pixel;
    } pix_write_t;

    // One pixel read request
    typedef struct packed {
        logic                  en;
        logic [`ADDR_BITS-1:0] addr;
    } pix_read_t;

    // Tagged write on the output port
    typedef struct packed {
        pix_write_t wr;
        level_t     level;
    } level_write_t;

endpackage

`default_nettype wire

// ==== verilog/image_loader.sv ====
`default_nettype none
`include "pyramid_consts.svh"

module image_loader (
    input wire clk_in,
    input wire rst_in,
    input wire load_start,
    output pyramid_pkg::pix_read_t ext_rd,
    input wire [`PIX_BITS-1:0] ext_pixel,
    output pyramid_pkg::pix_write_t load_wr
);

    // Request tracking across the memory latency
    logic [`EXT_LATENCY-1:0] vld_pipe;
    logic [`ADDR_BITS-1:0] addr_pipe [`EXT_LATENCY];

    // One read per cycle, row-major sweep of the whole frame
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            ext_rd <= '0;
        end else if (load_start) begin
            ext_rd.en <= 1'b1;
            ext_rd.addr <= '0;
        end else if (ext_rd.en) begin
            // Stop after the bottom-right pixel
            if (ext_rd.addr == `ADDR_BITS'(`IMG_WIDTH * `IMG_HEIGHT - 1)) begin
                ext_rd.en <= 1'b0;
            end else begin
                ext_rd.addr <= ext_rd.addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[`EXT_LATENCY-2:0], ext_rd.en};
        end
    end

    // Address travels alongside its valid bit
    always_ff @(posedge clk_in) begin
        addr_pipe[0] <= ext_rd.addr;
        for (int i = 1; i < `EXT_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    // Returning pixel paired with the address it was read from
    always_comb begin
        load_wr.valid = vld_pipe[`EXT_LATENCY-1];
        load_wr.addr = addr_pipe[`EXT_LATENCY-1];
        load_wr.pixel = ext_pixel;
    end

endmodule

`default_nettype wire

// ==== verilog/pyramid_sequencer.sv ====
`default_nettype none

module pyramid_sequencer (
    input wire clk_in,
    input wire rst_in,
    input wire start,
    input wire level_done,
    output logic load_start,
    output logic engine_start,
    output pyramid_pkg::kernel_op_t engine_op,
    output logic octave,
    output logic src_sel,
    output pyramid_pkg::level_t level,
    output logic pyramid_done
);

    pyramid_pkg::seq_state_t state;

    // Pass order, each pass ends on level_done from the writer
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= pyramid_pkg::IDLE;
            load_start <= 1'b0;
            engine_start <= 1'b0;
            pyramid_done <= 1'b0;
        end else begin
            // Pulses last a single cycle
            load_start <= 1'b0;
            engine_start <= 1'b0;
            pyramid_done <= 1'b0;
            case (state)
                pyramid_pkg::IDLE: begin
                    // start is only seen here, busy runs ignore it
                    if (start) begin
                        state <= pyramid_pkg::LOAD;
                        load_start <= 1'b1;
                    end
                end
                pyramid_pkg::LOAD: begin
                    if (level_done) begin
                        state <= pyramid_pkg::BLUR1;
                        engine_start <= 1'b1;
                    end
                end
                pyramid_pkg::BLUR1: begin
                    if (level_done) begin
                        state <= pyramid_pkg::HALVE;
                        engine_start <= 1'b1;
                    end
                end
                pyramid_pkg::HALVE: begin
                    if (level_done) begin
                        state <= pyramid_pkg::BLUR2;
                        engine_start <= 1'b1;
                    end
                end
                pyramid_pkg::BLUR2: begin
                    // Last level written, whole pyramid done
                    if (level_done) begin
                        state <= pyramid_pkg::IDLE;
                        pyramid_done <= 1'b1;
                    end
                end
                default: begin
                    state <= pyramid_pkg::IDLE;
                end
            endcase
        end
    end

    // Pass settings, steady for the whole pass
    always_comb begin
        engine_op = pyramid_pkg::OP_BLUR;
        octave = 1'b0;
        src_sel = 1'b1;
        level = pyramid_pkg::O1L1;
        case (state)
            pyramid_pkg::BLUR1: begin
                src_sel = 1'b0;
                level = pyramid_pkg::O1L2;
            end
            pyramid_pkg::HALVE: begin
                engine_op = pyramid_pkg::OP_HALVE;
                level = pyramid_pkg::O2L1;
            end
            pyramid_pkg::BLUR2: begin
                // Blur now runs on the small frame
                octave = 1'b1;
                src_sel = 1'b0;
                level = pyramid_pkg::O2L2;
            end
            default: begin
                // IDLE and LOAD fill buffer A
                src_sel = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/kernel_engine.sv ====
`default_nettype none
`include "pyramid_consts.svh"

module kernel_engine (
    input wire clk_in,
    input wire rst_in,
    input wire engine_start,
    input wire pyramid_pkg::kernel_op_t engine_op,
    input wire octave,
    output pyramid_pkg::pix_read_t buf_rd,
    input wire [`PIX_BITS-1:0] buf_pixel,
    output pyramid_pkg::pix_write_t engine_wr
);

    logic busy;
    logic [`ADDR_BITS-1:0] ox;
    logic [`ADDR_BITS-1:0] oy;
    logic [1:0] tx;
    logic [1:0] ty;
    logic [1:0] tap_end;
    logic [`ADDR_BITS-1:0] src_w;
    logic [`ADDR_BITS-1:0] src_h;
    logic [`ADDR_BITS-1:0] out_w;
    logic [`ADDR_BITS-1:0] out_h;
    logic [`ADDR_BITS-1:0] cx;
    logic [`ADDR_BITS-1:0] cy;
    logic [`ADDR_BITS-1:0] sx;
    logic [`ADDR_BITS-1:0] sy;
    // Tap info delayed to line up with the RAM data
    logic d_vld;
    logic d_first;
    logic d_last;
    logic [1:0] d_wsh;
    logic [`ADDR_BITS-1:0] d_out_addr;
    logic [`PIX_BITS+`BLUR_SHIFT-1:0] acc;
    logic [`PIX_BITS+`BLUR_SHIFT-1:0] sum;
    logic [`PIX_BITS+`BLUR_SHIFT-1:0] sum_shr;

    // Octave picks the source frame, halving quarters it
    assign src_w = octave ? `ADDR_BITS'(`IMG_WIDTH / 2) : `ADDR_BITS'(`IMG_WIDTH);
    assign src_h = octave ? `ADDR_BITS'(`IMG_HEIGHT / 2) : `ADDR_BITS'(`IMG_HEIGHT);
    assign out_w = (engine_op == pyramid_pkg::OP_HALVE) ? (src_w >> 1) : src_w;
    assign out_h = (engine_op == pyramid_pkg::OP_HALVE) ? (src_h >> 1) : src_h;
    // 3x3 window or 2x2 block
    assign tap_end = (engine_op == pyramid_pkg::OP_HALVE) ? 2'd1 : 2'd2;

    // Output walk, taps innermost
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            ox <= '0;
            oy <= '0;
            tx <= '0;
            ty <= '0;
        end else if (engine_start) begin
            busy <= 1'b1;
            ox <= '0;
            oy <= '0;
            tx <= '0;
            ty <= '0;
        end else if (busy) begin
            if (tx != tap_end) begin
                tx <= tx + 1'b1;
            end else begin
                tx <= '0;
                if (ty != tap_end) begin
                    ty <= ty + 1'b1;
                end else begin
                    ty <= '0;
                    if (ox != out_w - 1'b1) begin
                        ox <= ox + 1'b1;
                    end else begin
                        ox <= '0;
                        if (oy != out_h - 1'b1) begin
                            oy <= oy + 1'b1;
                        end else begin
                            busy <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    // Source coordinate of the current tap
    always_comb begin
        // Blur taps sit one left and one up of the counters
        cx = ox + `ADDR_BITS'(tx);
        cy = oy + `ADDR_BITS'(ty);
        if (engine_op == pyramid_pkg::OP_HALVE) begin
            sx = (ox << 1) + `ADDR_BITS'(tx);
            sy = (oy << 1) + `ADDR_BITS'(ty);
        end else begin
            // Clamp to the frame edge
            sx = (cx == '0) ? '0 : ((cx > src_w) ? src_w - 1'b1 : cx - 1'b1);
            sy = (cy == '0) ? '0 : ((cy > src_h) ? src_h - 1'b1 : cy - 1'b1);
        end
    end

    always_comb begin
        buf_rd.en = busy;
        buf_rd.addr = sy * src_w + sx;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            d_vld <= 1'b0;
        end else begin
            d_vld <= busy;
        end
        d_first <= (tx == 2'd0) && (ty == 2'd0);
        d_last <= (tx == tap_end) && (ty == tap_end);
        // Weight 1, 2 or 4 as a shift, centre row and column double it
        if (engine_op == pyramid_pkg::OP_HALVE) begin
            d_wsh <= 2'd0;
        end else begin
            d_wsh <= 2'(tx == 2'd1) + 2'(ty == 2'd1);
        end
        d_out_addr <= oy * out_w + ox;
    end

    // First tap restarts the sum
    assign sum = (d_first ? '0 : acc) + ({{`BLUR_SHIFT{1'b0}}, buf_pixel} << d_wsh);
    assign sum_shr = sum >> ((engine_op == pyramid_pkg::OP_HALVE) ? `HALVE_SHIFT : `BLUR_SHIFT);

    always_ff @(posedge clk_in) begin
        if (d_vld) begin
            acc <= sum;
        end
    end

    // Write one cycle after the last tap's data
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            engine_wr.valid <= 1'b0;
        end else begin
            engine_wr.valid <= d_vld && d_last;
        end
        if (d_vld && d_last) begin
            engine_wr.addr <= d_out_addr;
            engine_wr.pixel <= sum_shr[`PIX_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/frame_ram.sv ====
`default_nettype none
`include "pyramid_consts.svh"

module frame_ram (
    input wire clk_in,
    input wire pyramid_pkg::pix_write_t wr,
    input wire pyramid_pkg::pix_read_t rd,
    output logic [`PIX_BITS-1:0] rd_pixel
);

    // One full octave-1 frame
    logic [`PIX_BITS-1:0] mem [1 << `ADDR_BITS];

    always_ff @(posedge clk_in) begin
        if (wr.valid) begin
            mem[wr.addr] <= wr.pixel;
        end
        // Registered read, data a cycle after the request
        if (rd.en) begin
            rd_pixel <= mem[rd.addr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/frame_buffers.sv ====
`default_nettype none
`include "pyramid_consts.svh"

module frame_buffers (
    input wire clk_in,
    input wire src_sel,
    input wire pyramid_pkg::pix_write_t buf_wr,
    input wire pyramid_pkg::pix_read_t buf_rd,
    output logic [`PIX_BITS-1:0] buf_pixel
);

    pyramid_pkg::pix_write_t wr_a;
    pyramid_pkg::pix_write_t wr_b;
    pyramid_pkg::pix_read_t rd_a;
    pyramid_pkg::pix_read_t rd_b;
    logic [`PIX_BITS-1:0] pix_a;
    logic [`PIX_BITS-1:0] pix_b;
    logic sel_q;

    // src_sel 0 reads A and writes B, 1 the other way round
    always_comb begin
        wr_a = buf_wr;
        wr_b = buf_wr;
        wr_a.valid = buf_wr.valid && src_sel;
        wr_b.valid = buf_wr.valid && !src_sel;
        rd_a = buf_rd;
        rd_b = buf_rd;
        rd_a.en = buf_rd.en && !src_sel;
        rd_b.en = buf_rd.en && src_sel;
    end

    frame_ram u_ram_a (
        .clk_in(clk_in),
        .wr(wr_a),
        .rd(rd_a),
        .rd_pixel(pix_a)
    );

    frame_ram u_ram_b (
        .clk_in(clk_in),
        .wr(wr_b),
        .rd(rd_b),
        .rd_pixel(pix_b)
    );

    // Read data comes back a cycle late, so steer it with the delayed select
    always_ff @(posedge clk_in) begin
        sel_q <= src_sel;
    end

    assign buf_pixel = sel_q ? pix_b : pix_a;

endmodule

`default_nettype wire

// ==== verilog/level_writer.sv ====
`default_nettype none
`include "pyramid_consts.svh"

module level_writer (
    input wire clk_in,
    input wire rst_in,
    input wire pyramid_pkg::pix_write_t load_wr,
    input wire pyramid_pkg::pix_write_t engine_wr,
    input wire pyramid_pkg::level_t level,
    output pyramid_pkg::pix_write_t buf_wr,
    output pyramid_pkg::level_write_t lvl_wr,
    output logic level_done
);

    pyramid_pkg::pix_write_t merged;
    pyramid_pkg::level_t lvl_q;
    logic [`ADDR_BITS-1:0] wr_cnt;
    logic [`ADDR_BITS-1:0] last_idx;

    // Loader and engine never write in the same cycle
    assign merged = load_wr.valid ? load_wr : engine_wr;

    // Octave-2 levels are a quarter the size
    assign last_idx = (level == pyramid_pkg::O1L1 || level == pyramid_pkg::O1L2) ?
                      `ADDR_BITS'(`IMG_WIDTH * `IMG_HEIGHT - 1) :
                      `ADDR_BITS'((`IMG_WIDTH / 2) * (`IMG_HEIGHT / 2) - 1);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            buf_wr.valid <= 1'b0;
            lvl_q <= pyramid_pkg::O1L1;
            wr_cnt <= '0;
            level_done <= 1'b0;
        end else begin
            buf_wr.valid <= merged.valid;
            lvl_q <= level;
            // Flag lines up with the last pixel on the output
            level_done <= merged.valid && (wr_cnt == last_idx);
            if (merged.valid) begin
                wr_cnt <= (wr_cnt == last_idx) ? '0 : wr_cnt + 1'b1;
            end
        end
        buf_wr.addr <= merged.addr;
        buf_wr.pixel <= merged.pixel;
    end

    // Same registered write goes out, tagged
    always_comb begin
        lvl_wr.wr = buf_wr;
        lvl_wr.level = lvl_q;
    end

endmodule

`default_nettype wire

// ==== verilog/gaussian_pyramid.sv ====
`default_nettype none
`include "pyramid_consts.svh"

module gaussian_pyramid (
    input wire clk_in,
    input wire rst_in,
    input wire start,
    output pyramid_pkg::pix_read_t ext_rd,
    input wire [`PIX_BITS-1:0] ext_pixel,
    output pyramid_pkg::level_write_t lvl_wr,
    output logic pyramid_done
);

    // Sequencer control
    logic load_start;
    logic engine_start;
    pyramid_pkg::kernel_op_t engine_op;
    logic octave;
    logic src_sel;
    pyramid_pkg::level_t level;
    logic level_done;
    // Pixel streams
    pyramid_pkg::pix_write_t load_wr;
    pyramid_pkg::pix_write_t engine_wr;
    pyramid_pkg::pix_write_t buf_wr;
    pyramid_pkg::pix_read_t buf_rd;
    logic [`PIX_BITS-1:0] buf_pixel;

    // Input side
    image_loader u_image_loader (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .load_start(load_start),
        .ext_rd(ext_rd),
        .ext_pixel(ext_pixel),
        .load_wr(load_wr)
    );

    pyramid_sequencer u_pyramid_sequencer (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .start(start),
        .level_done(level_done),
        .load_start(load_start),
        .engine_start(engine_start),
        .engine_op(engine_op),
        .octave(octave),
        .src_sel(src_sel),
        .level(level),
        .pyramid_done(pyramid_done)
    );

    // Shared blur and halve datapath
    kernel_engine u_kernel_engine (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .engine_start(engine_start),
        .engine_op(engine_op),
        .octave(octave),
        .buf_rd(buf_rd),
        .buf_pixel(buf_pixel),
        .engine_wr(engine_wr)
    );

    frame_buffers u_frame_buffers (
        .clk_in(clk_in),
        .src_sel(src_sel),
        .buf_wr(buf_wr),
        .buf_rd(buf_rd),
        .buf_pixel(buf_pixel)
    );

    // Output side, also feeds the ping-pong buffers
    level_writer u_level_writer (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .load_wr(load_wr),
        .engine_wr(engine_wr),
        .level(level),
        .buf_wr(buf_wr),
        .lvl_wr(lvl_wr),
        .level_done(level_done)
    );

endmodule

`default_nettype wire

// ==== testbench/pyramid_sva.sv ====
`default_nettype none

module pyramid_sva (
    input wire clk_in,
    input wire rst_in,
    input wire pyramid_pkg::level_write_t lvl_wr,
    input wire pyramid_done
);
    timeunit 1ns;
    timeprecision 100ps;

    // Tag of the latest write in the current run
    logic [1:0] last_level;

    always_ff @(posedge clk_in) begin
        if (rst_in || pyramid_done) begin
            last_level <= '0;
        end else if (lvl_wr.wr.valid) begin
            last_level <= lvl_wr.level;
        end
    end

    // Outputs quiet once reset has been applied for a cycle
    reset_quiet: assert property (@(posedge clk_in)
        rst_in && $past(rst_in) |-> !lvl_wr.wr.valid && !pyramid_done)
        else $error("Output write or done active while in reset");

    // Single-cycle done pulse
    done_single: assert property (@(posedge clk_in) disable iff (rst_in)
        pyramid_done |=> !pyramid_done)
        else $error("pyramid_done held high for more than one cycle");

    // Levels come out in order O1L1 to O2L2
    level_order: assert property (@(posedge clk_in) disable iff (rst_in)
        lvl_wr.wr.valid |-> 2'(lvl_wr.level) >= last_level)
        else $error("Level tag went backwards within a run");

endmodule

bind gaussian_pyramid pyramid_sva u_pyramid_sva (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .lvl_wr(lvl_wr),
    .pyramid_done(pyramid_done)
);

`default_nettype wire

// ==== testbench/pyramid_tb.sv ====
`default_nettype none
`include "pyramid_consts.svh"

module pyramid_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME1 = `IMG_WIDTH * `IMG_HEIGHT;
    localparam int FRAME2 = (`IMG_WIDTH / 2) * (`IMG_HEIGHT / 2);
    localparam int RUNS = 3;
    // Load, blur at 9 taps, halve at 4 taps, small blur, plus idle time
    localparam int RUN_CYCLES = FRAME1 + FRAME1 * 9 + FRAME2 * 4 + FRAME2 * 9 + 400;
    localparam int MAX_CYCLES = RUNS * RUN_CYCLES + 2000;

    logic clk_in;
    logic rst_in;
    logic start;
    logic [`PIX_BITS-1:0] ext_pixel;
    pyramid_pkg::pix_read_t ext_rd;
    pyramid_pkg::level_write_t lvl_wr;
    logic pyramid_done;

    // Source image and its read pipe
    logic [`PIX_BITS-1:0] src_mem [FRAME1];
    logic [`PIX_BITS-1:0] rd_pipe [`EXT_LATENCY];
    // Expected pixels per level tag
    logic [`PIX_BITS-1:0] ref_pix [4][FRAME1];
    string level_names [4] = '{"O1L1", "O1L2", "O2L1", "O2L2"};

    logic [31:0] rng_state;
    int cycle_cnt;
    int run_no;
    int exp_level;
    int exp_addr;
    int level_errs;
    int done_cnt;
    int early_done;
    int stray_writes;
    int err_cnt;
    int test_cnt;
    int fail_tests;

    gaussian_pyramid u_gaussian_pyramid (
        .clk_in(clk_in),
        .rst_in(rst_in),
        .start(start),
        .ext_rd(ext_rd),
        .ext_pixel(ext_pixel),
        .lvl_wr(lvl_wr),
        .pyramid_done(pyramid_done)
    );

    initial begin
        clk_in = 1'b0;
    end

    always #2 clk_in = ~clk_in;

    // Fixed-latency source memory
    always @(posedge clk_in) begin
        rd_pipe[0] <= src_mem[ext_rd.addr];
        for (int i = 1; i < `EXT_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    always @(posedge clk_in) begin
        #1;
        ext_pixel = rd_pipe[`EXT_LATENCY-1];
    end

    // Run limit
    always @(posedge clk_in) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the pyramid never finished", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int clamp_coord(input int v, input int hi);
        return (v < 0) ? 0 : ((v > hi) ? hi : v);
    endfunction

    function automatic int level_size(input int lvl);
        return (lvl < 2) ? FRAME1 : FRAME2;
    endfunction

    task automatic fill_source();
        for (int a = 0; a < FRAME1; a++) begin
            rng_state = next_random(rng_state);
            src_mem[a] = rng_state[7:0];
        end
    endtask

    // Binomial 1 2 1 blur with edge clamping
    task automatic blur_level(input int src, input int dst, input int w, input int h);
        int sum;
        int sx;
        int sy;
        int wt;
        for (int y = 0; y < h; y++) begin
            for (int x = 0; x < w; x++) begin
                sum = 0;
                for (int dy = -1; dy <= 1; dy++) begin
                    for (int dx = -1; dx <= 1; dx++) begin
                        sx = clamp_coord(x + dx, w - 1);
                        sy = clamp_coord(y + dy, h - 1);
                        wt = ((dx == 0) ? 2 : 1) * ((dy == 0) ? 2 : 1);
                        sum = sum + wt * int'(ref_pix[src][sy * w + sx]);
                    end
                end
                ref_pix[dst][y * w + x] = 8'(sum >> `BLUR_SHIFT);
            end
        end
    endtask

    // 2x2 block average, w and h are the source size
    task automatic halve_level(input int src, input int dst, input int w, input int h);
        int sum;
        for (int y = 0; y < h / 2; y++) begin
            for (int x = 0; x < w / 2; x++) begin
                sum = int'(ref_pix[src][(2 * y) * w + 2 * x]);
                sum = sum + int'(ref_pix[src][(2 * y) * w + 2 * x + 1]);
                sum = sum + int'(ref_pix[src][(2 * y + 1) * w + 2 * x]);
                sum = sum + int'(ref_pix[src][(2 * y + 1) * w + 2 * x + 1]);
                ref_pix[dst][y * (w / 2) + x] = 8'(sum >> `HALVE_SHIFT);
            end
        end
    endtask

    task automatic compute_reference();
        for (int a = 0; a < FRAME1; a++) begin
            ref_pix[0][a] = src_mem[a];
        end
        blur_level(0, 1, `IMG_WIDTH, `IMG_HEIGHT);
        halve_level(1, 2, `IMG_WIDTH, `IMG_HEIGHT);
        blur_level(2, 3, `IMG_WIDTH / 2, `IMG_HEIGHT / 2);
    endtask

    task automatic finish_test(input string name, input int errs);
        test_cnt++;
        if (errs != 0) begin
            fail_tests++;
        end
        $display("test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failing", errs);
    endtask

    // One output write against the expected level, address and pixel
    task automatic check_write();
        string name;
        assert (exp_level < 4) else begin
            $display("Write to address %0d seen outside a run", lvl_wr.wr.addr);
            stray_writes++;
            err_cnt++;
        end
        if (exp_level >= 4) begin
            return;
        end
        name = $sformatf("run%0d_%s", run_no, level_names[exp_level]);
        assert (int'(lvl_wr.level) == exp_level) else begin
            $display("ERR %s level tag: expected %0d, actual %0d",
                     name, exp_level, lvl_wr.level);
            level_errs++;
            err_cnt++;
        end
        assert (int'(lvl_wr.wr.addr) == exp_addr) else begin
            $display("ERR %s address: expected %0d, actual %0d",
                     name, exp_addr, lvl_wr.wr.addr);
            level_errs++;
            err_cnt++;
        end
        assert (lvl_wr.wr.pixel == ref_pix[exp_level][exp_addr]) else begin
            $display("ERR %s pixel %0d: expected 0x%02h, actual 0x%02h",
                     name, exp_addr, ref_pix[exp_level][exp_addr], lvl_wr.wr.pixel);
            level_errs++;
            err_cnt++;
        end
        exp_addr++;
        if (exp_addr == level_size(exp_level)) begin
            finish_test(name, level_errs);
            level_errs = 0;
            exp_addr = 0;
            exp_level++;
        end
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk_in) begin
        if (!rst_in && lvl_wr.wr.valid) begin
            check_write();
        end
        if (!rst_in && pyramid_done) begin
            done_cnt++;
            assert (exp_level == 4) else begin
                $display("pyramid_done arrived before all four levels were written");
                early_done++;
                err_cnt++;
            end
        end
    end

    task automatic pulse_start();
        @(posedge clk_in);
        #1;
        start = 1'b1;
        @(posedge clk_in);
        #1;
        start = 1'b0;
    endtask

    task automatic do_run(input int r);
        int done_before;
        int early_before;
        int stray_before;
        int idle_reads;
        int errs;
        run_no = r;
        fill_source();
        compute_reference();
        done_before = done_cnt;
        early_before = early_done;
        stray_before = stray_writes;
        exp_level = 0;
        exp_addr = 0;
        level_errs = 0;
        pulse_start();
        // Extra start once the first blur has begun
        while (exp_level < 1) begin
            @(posedge clk_in);
        end
        pulse_start();
        while (done_cnt == done_before) begin
            @(posedge clk_in);
        end
        // Idle window, no reads or writes expected
        idle_reads = 0;
        for (int i = 0; i < 50; i++) begin
            @(negedge clk_in);
            if (ext_rd.en) begin
                idle_reads++;
            end
        end
        errs = 0;
        assert (done_cnt == done_before + 1 && early_done == early_before) else begin
            $display("pyramid_done pulsed %0d times in run %0d, %0d of them early",
                     done_cnt - done_before, r, early_done - early_before);
            errs++;
            err_cnt++;
        end
        finish_test($sformatf("run%0d_done", r), errs);
        errs = 0;
        assert (idle_reads == 0 && stray_writes == stray_before) else begin
            $display("Run %0d kept reading or writing after pyramid_done", r);
            errs++;
            err_cnt++;
        end
        finish_test($sformatf("run%0d_busy_start_ignored", r), errs);
    endtask

    initial begin
        rst_in = 1'b1;
        start = 1'b0;
        ext_pixel = '0;
        rng_state = 32'd47;
        cycle_cnt = 0;
        run_no = 0;
        // No writes expected before the first run
        exp_level = 4;
        exp_addr = 0;
        level_errs = 0;
        done_cnt = 0;
        early_done = 0;
        stray_writes = 0;
        err_cnt = 0;
        test_cnt = 0;
        fail_tests = 0;
        repeat (10) @(posedge clk_in);
        #1;
        rst_in = 1'b0;
        for (int r = 1; r <= RUNS; r++) begin
            do_run(r);
        end
        $display("tests run %0d, tests failing %0d, errors %0d", test_cnt, fail_tests, err_cnt);
        if (err_cnt == 0 && fail_tests == 0 && test_cnt == RUNS * 6) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
verilog/pyramid_pkg.sv
verilog/image_loader.sv
verilog/pyramid_sequencer.sv
verilog/kernel_engine.sv
verilog/frame_ram.sv
verilog/frame_buffers.sv
verilog/level_writer.sv
verilog/gaussian_pyramid.sv
testbench/pyramid_sva.sv
testbench/pyramid_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the Gaussian pyramid testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f project.f --top-module pyramid_tb -o pyramid_sim
./obj_dir/pyramid_sim | tee sim.log
if grep -q "TESTBENCH PASSED" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
